// ==== common/gpr_consts.svh ====
`ifndef GPR_CONSTS_SVH
`define GPR_CONSTS_SVH

// datapath width and register count of the RV32E operand stage.
`define GPR_XLEN 32
`define GPR_NREGS 16

// mstatus comes out of reset with MPP set to machine mode.
`define GPR_MSTATUS_RST 32'h1800

// written on ecall entry.
`define GPR_MCAUSE_ECALL 32'hb
`define GPR_MSTATUS_TRAP 32'h1800

`endif

// ==== common/gpr_pkg.sv ====
`default_nettype none

`include "gpr_consts.svh"

package gpr_pkg;

  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } gpr_state_e;

  // target of an explicit csr write.
  typedef enum logic [2:0] {
    CSR_NONE    = 3'd0,
    CSR_MTVEC   = 3'd1,
    CSR_MEPC    = 3'd2,
    CSR_MSTATUS = 3'd3,
    CSR_MCAUSE  = 3'd4
  } csr_sel_e;

  typedef enum logic [1:0] {
    SYS_NONE  = 2'd0,
    SYS_ECALL = 2'd1,
    SYS_MRET  = 2'd2
  } sys_op_e;

  typedef struct packed {
    logic                          reg_we;
    logic [$clog2(`GPR_NREGS)-1:0] rd;
    logic [`GPR_XLEN-1:0]          reg_wdata;
    csr_sel_e                      csr_sel;
    logic [`GPR_XLEN-1:0]          csr_wdata;
    sys_op_e                       sys_op;
    logic [`GPR_XLEN-1:0]          pc;     // pc of the retiring instruction.
  } wb_req_t;

  typedef struct packed {
    logic [$clog2(`GPR_NREGS)-1:0] rs1;
    logic [$clog2(`GPR_NREGS)-1:0] rs2;
  } dec_req_t;

  typedef struct packed {
    logic [`GPR_XLEN-1:0] src1;
    logic [`GPR_XLEN-1:0] src2;
    logic [`GPR_XLEN-1:0] mtvec;
    logic [`GPR_XLEN-1:0] mepc;
  } exe_rsp_t;

endpackage

`default_nettype wire

// ==== gpr/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpr_consts.svh"

module csr_file (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  commit,
  input  wire gpr_pkg::wb_req_t wb_req,
  output logic [`GPR_XLEN-1:0] mtvec,
  output logic [`GPR_XLEN-1:0] mepc,
  output logic [`GPR_XLEN-1:0] mstatus,
  output logic [`GPR_XLEN-1:0] mcause
);

  logic [`GPR_XLEN-1:0] mtvec_d;
  logic [`GPR_XLEN-1:0] mepc_d;
  logic [`GPR_XLEN-1:0] mstatus_d;
  logic [`GPR_XLEN-1:0] mcause_d;
  logic [`GPR_XLEN-1:0] mret_status;

  // mret restores MIE from MPIE, sets MPIE and drops MPP to user.
  always_comb begin
    mret_status        = mstatus;
    mret_status[3]     = mstatus[7];
    mret_status[7]     = 1'b1;
    mret_status[12:11] = 2'b00;
  end

  always_comb begin
    mtvec_d   = mtvec;
    mepc_d    = mepc;
    mstatus_d = mstatus;
    mcause_d  = mcause;

    case (wb_req.csr_sel)
      gpr_pkg::CSR_MTVEC:   mtvec_d   = wb_req.csr_wdata;
      gpr_pkg::CSR_MEPC:    mepc_d    = wb_req.csr_wdata;
      gpr_pkg::CSR_MSTATUS: mstatus_d = wb_req.csr_wdata;
      gpr_pkg::CSR_MCAUSE:  mcause_d  = wb_req.csr_wdata;
      default: ;
    endcase

    // trap side effects come last so they override an explicit write.
    case (wb_req.sys_op)
      gpr_pkg::SYS_ECALL: begin
        mepc_d    = wb_req.pc;
        mcause_d  = `GPR_MCAUSE_ECALL;
        mstatus_d = `GPR_MSTATUS_TRAP;
      end
      gpr_pkg::SYS_MRET: begin
        mstatus_d = mret_status;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mtvec   <= '0;
      mepc    <= '0;
      mstatus <= `GPR_MSTATUS_RST;
      mcause  <= '0;
    end else if (commit) begin
      mtvec   <= mtvec_d;
      mepc    <= mepc_d;
      mstatus <= mstatus_d;
      mcause  <= mcause_d;
    end
  end

  a_sys_op_legal: assert property (
    @(posedge clk) disable iff (rst)
    commit |-> (wb_req.sys_op inside {gpr_pkg::SYS_NONE, gpr_pkg::SYS_ECALL,
                                      gpr_pkg::SYS_MRET})
  );

endmodule

`default_nettype wire

// ==== gpr/gpr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpr_ctrl (
  input  wire  clk,
  input  wire  rst,
  input  wire  wb_valid,
  input  wire  dec_valid,
  input  wire  exe_ready,
  output logic in_ready,
  output logic out_valid,
  output logic accept,
  output logic commit
);

  gpr_pkg::gpr_state_e state;
  gpr_pkg::gpr_state_e state_d;

  assign in_ready  = (state == gpr_pkg::IDLE);
  assign out_valid = (state == gpr_pkg::BUSY);

  // a writeback alone, a decode alone or both together start one transfer.
  assign accept = in_ready & (wb_valid | dec_valid);
  assign commit = in_ready & wb_valid;

  always_comb begin
    state_d = state;
    case (state)
      gpr_pkg::IDLE: begin
        if (accept) begin
          state_d = gpr_pkg::BUSY;
        end
      end
      gpr_pkg::BUSY: begin
        if (exe_ready) begin
          state_d = gpr_pkg::IDLE;  // execute took the operands.
        end
      end
      default: state_d = gpr_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= gpr_pkg::IDLE;
    end else begin
      state <= state_d;
    end
  end

  a_no_overlap: assert property (
    @(posedge clk) disable iff (rst)
    !(in_ready && out_valid)
  );

  // the response may not be withdrawn before execute takes it.
  a_valid_hold: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !exe_ready) |=> out_valid
  );

endmodule

`default_nettype wire

// ==== gpr/gpr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpr_consts.svh"

module gpr_file (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  commit,
  input  wire                  accept,
  input  wire                  dec_valid,
  input  wire gpr_pkg::wb_req_t  wb_req,
  input  wire gpr_pkg::dec_req_t dec_req,
  output logic [`GPR_XLEN-1:0] src1,
  output logic [`GPR_XLEN-1:0] src2
);

  logic [`GPR_XLEN-1:0]          regs [`GPR_NREGS];
  logic [$clog2(`GPR_NREGS)-1:0] rs1_q;
  logic [$clog2(`GPR_NREGS)-1:0] rs2_q;
  logic                          wr_en;

  assign wr_en = commit & wb_req.reg_we & (wb_req.rd != '0);  // x0 is never written.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (wr_en) begin
      regs[wb_req.rd] <= wb_req.reg_wdata;
    end
  end

  // a writeback-only request reads x0 on both ports.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rs1_q <= '0;
      rs2_q <= '0;
    end else if (accept) begin
      rs1_q <= dec_valid ? dec_req.rs1 : '0;
      rs2_q <= dec_valid ? dec_req.rs2 : '0;
    end
  end

  // reads follow the captured indices, so a write on the accept edge is seen.
  assign src1 = regs[rs1_q];
  assign src2 = regs[rs2_q];

  a_x0_zero: assert property (
    @(posedge clk) disable iff (rst)
    regs[0] == '0
  );

endmodule

`default_nettype wire

// ==== gpr_stage.f ====
+incdir+common
common/gpr_pkg.sv
gpr/gpr_ctrl.sv
gpr/gpr_file.sv
gpr/csr_file.sv
hdl/retire_counter.sv
hdl/gpr_stage.sv
verif/gpr_stage_tb.sv

// ==== hdl/gpr_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpr_stage (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   wb_valid,
  input  wire                   dec_valid,
  input  wire gpr_pkg::wb_req_t  wb_req,
  input  wire gpr_pkg::dec_req_t dec_req,
  input  wire                   exe_ready,
  output logic                  in_ready,
  output logic                  out_valid,
  output gpr_pkg::exe_rsp_t     exe_rsp,
  output logic [31:0]           mstatus,
  output logic [31:0]           mcause,
  output logic [63:0]           instret
);

  logic        accept;
  logic        commit;
  logic [31:0] src1;
  logic [31:0] src2;
  logic [31:0] mtvec;
  logic [31:0] mepc;

  gpr_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .wb_valid  (wb_valid),
    .dec_valid (dec_valid),
    .exe_ready (exe_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .accept    (accept),
    .commit    (commit)
  );

  gpr_file u_gpr_file (
    .clk       (clk),
    .rst       (rst),
    .commit    (commit),
    .accept    (accept),
    .dec_valid (dec_valid),
    .wb_req    (wb_req),
    .dec_req   (dec_req),
    .src1      (src1),
    .src2      (src2)
  );

  csr_file u_csr_file (
    .clk     (clk),
    .rst     (rst),
    .commit  (commit),
    .wb_req  (wb_req),
    .mtvec   (mtvec),
    .mepc    (mepc),
    .mstatus (mstatus),
    .mcause  (mcause)
  );

  retire_counter u_retire (
    .clk     (clk),
    .rst     (rst),
    .commit  (commit),
    .instret (instret)
  );

  assign exe_rsp = '{src1: src1, src2: src2, mtvec: mtvec, mepc: mepc};

endmodule

`default_nettype wire

// ==== hdl/retire_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_counter (
  input  wire         clk,
  input  wire         rst,
  input  wire         commit,
  output logic [63:0] instret
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      instret <= '0;
    end else if (commit) begin
      instret <= instret + 64'd1;  // wraps at the top.
    end
  end

  // a commit seen while reset is still high does not count.
  a_count_step: assert property (
    @(posedge clk) disable iff (rst)
    instret == ($past(commit & ~rst) ? $past(instret) + 64'd1 : $past(instret))
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the gpr_stage testbench with Verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f gpr_stage.f --top-module gpr_stage_tb \
  -Mdir obj_dir -o sim_gpr_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_gpr_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" sim.log; then
  exit 1
fi
exit 0

// ==== verif/gpr_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpr_consts.svh"

module gpr_stage_tb;

  localparam int RST_CYCLES = 8;
  localparam int N_RESET = 1;
  localparam int N_REG = 200;
  localparam int N_CSR = 100;
  localparam int N_SYS = 100;
  localparam int N_BP = 200;
  localparam int WATCHDOG_NS = (RST_CYCLES + N_RESET + N_REG + N_CSR + N_SYS + N_BP) * 4 * 10;

  logic                clk;
  logic                rst;
  logic                wb_valid;
  logic                dec_valid;
  gpr_pkg::wb_req_t    wb_req;
  gpr_pkg::dec_req_t   dec_req;
  logic                exe_ready;
  logic                in_ready;
  logic                out_valid;
  gpr_pkg::exe_rsp_t   exe_rsp;
  logic [31:0]         mstatus;
  logic [31:0]         mcause;
  logic [63:0]         instret;

  logic [31:0]          lfsr;
  int                   errors;
  int                   checks;
  logic [`GPR_XLEN-1:0] m_regs [`GPR_NREGS];
  logic [31:0]          m_mtvec;
  logic [31:0]          m_mepc;
  logic [31:0]          m_mstatus;
  logic [31:0]          m_mcause;
  logic [63:0]          m_instret;
  logic [3:0]           m_rs1;
  logic [3:0]           m_rs2;
  logic                 m_busy;

  gpr_stage dut0 (
    .clk       (clk),
    .rst       (rst),
    .wb_valid  (wb_valid),
    .dec_valid (dec_valid),
    .wb_req    (wb_req),
    .dec_req   (dec_req),
    .exe_ready (exe_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .exe_rsp   (exe_rsp),
    .mstatus   (mstatus),
    .mcause    (mcause),
    .instret   (instret)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      $display("CHECK FAILED at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic reset_model();
    int i;
    for (i = 0; i < `GPR_NREGS; i++) begin
      m_regs[i] = '0;
    end
    m_mtvec = '0;
    m_mepc = '0;
    m_mstatus = `GPR_MSTATUS_RST;
    m_mcause = '0;
    m_instret = '0;
    m_rs1 = '0;
    m_rs2 = '0;
    m_busy = 1'b0;
  endtask

  task automatic check_outputs();
    compare_value("in_ready", 64'(!m_busy), 64'(in_ready));
    compare_value("out_valid", 64'(m_busy), 64'(out_valid));
    compare_value("exe_rsp.src1", 64'(m_regs[m_rs1]), 64'(exe_rsp.src1));
    compare_value("exe_rsp.src2", 64'(m_regs[m_rs2]), 64'(exe_rsp.src2));
    compare_value("exe_rsp.mtvec", 64'(m_mtvec), 64'(exe_rsp.mtvec));
    compare_value("exe_rsp.mepc", 64'(m_mepc), 64'(exe_rsp.mepc));
    compare_value("mstatus", 64'(m_mstatus), 64'(mstatus));
    compare_value("mcause", 64'(m_mcause), 64'(mcause));
    compare_value("instret", m_instret, instret);
  endtask

  // the accept edge: write first, then capture the read indices.
  task automatic apply_accept(input logic wb_v, input logic dec_v,
                              input gpr_pkg::wb_req_t w, input gpr_pkg::dec_req_t d);
    logic [31:0] old_status;
    if (wb_v) begin
      old_status = m_mstatus;
      if (w.reg_we && w.rd != 4'd0) begin
        m_regs[w.rd] = w.reg_wdata;
      end
      case (w.csr_sel)
        gpr_pkg::CSR_MTVEC:   m_mtvec = w.csr_wdata;
        gpr_pkg::CSR_MEPC:    m_mepc = w.csr_wdata;
        gpr_pkg::CSR_MSTATUS: m_mstatus = w.csr_wdata;
        gpr_pkg::CSR_MCAUSE:  m_mcause = w.csr_wdata;
        default: ;
      endcase
      if (w.sys_op == gpr_pkg::SYS_ECALL) begin
        m_mepc = w.pc;
        m_mcause = `GPR_MCAUSE_ECALL;
        m_mstatus = `GPR_MSTATUS_TRAP;
      end else if (w.sys_op == gpr_pkg::SYS_MRET) begin
        m_mstatus = old_status;
        m_mstatus[3] = old_status[7];
        m_mstatus[7] = 1'b1;
        m_mstatus[12:11] = 2'b00;
      end
      m_instret = m_instret + 64'd1;
    end
    m_rs1 = dec_v ? d.rs1 : 4'd0;
    m_rs2 = dec_v ? d.rs2 : 4'd0;
    m_busy = 1'b1;
  endtask

  // mode 0 decode only, 1 registers, 2 csr writes, 3 system ops, 4 everything.
  task automatic make_req(input int mode, output logic wb_v, output logic dec_v,
                          output gpr_pkg::wb_req_t w, output gpr_pkg::dec_req_t d);
    logic [31:0] r;
    take_bits(16, r);
    wb_v = (mode == 0) ? 1'b0 : ((mode == 1 || mode == 4) ? r[0] : 1'b1);
    dec_v = (mode == 0) ? 1'b1 : (r[1] | ~wb_v);
    w.reg_we = r[2];
    w.rd = r[7:4];
    d.rs1 = r[11:8];
    d.rs2 = r[15:12];
    if (mode == 1 && r[3]) begin
      d.rs1 = w.rd;  // read back the register written by the same request.
    end
    take_bits(5, r);
    w.csr_sel = (mode >= 2) ? gpr_pkg::csr_sel_e'(r[2:0] % 3'd5) : gpr_pkg::CSR_NONE;
    w.sys_op = gpr_pkg::SYS_NONE;
    if (mode >= 3) begin
      w.sys_op = gpr_pkg::sys_op_e'((r[4:3] == 2'd3) ? 2'd0 : r[4:3]);
    end
    take_bits(32, r);
    w.reg_wdata = r;
    take_bits(32, r);
    w.csr_wdata = r;
    take_bits(32, r);
    w.pc = r;
  endtask

  task automatic run_txn(input logic wb_v, input logic dec_v, input gpr_pkg::wb_req_t w,
                         input gpr_pkg::dec_req_t d, input logic bp);
    logic [31:0] r;
    logic        done;
    check_outputs();
    wb_valid = wb_v;
    dec_valid = dec_v;
    wb_req = w;
    dec_req = d;
    exe_ready = 1'b0;
    apply_accept(wb_v, dec_v, w, d);
    next_cycle();
    done = 1'b0;
    while (!done) begin
      check_outputs();
      take_bits(3, r);
      wb_valid = r[0];  // stray requests while busy must be ignored.
      dec_valid = r[1];
      exe_ready = bp ? r[2] : 1'b1;
      done = exe_ready;
      next_cycle();
    end
    m_busy = 1'b0;
    wb_valid = 1'b0;
    dec_valid = 1'b0;
    exe_ready = 1'b0;
    check_outputs();
  endtask

  task automatic run_test(input string name, input int mode, input int count);
    int                start;
    int                i;
    logic              wb_v;
    logic              dec_v;
    gpr_pkg::wb_req_t  w;
    gpr_pkg::dec_req_t d;
    logic [31:0]       r;
    start = errors;
    for (i = 0; i < count; i++) begin
      if (mode == 4) begin
        take_bits(1, r);
        if (r[0]) begin
          next_cycle();  // an idle cycle must not start a transfer.
          check_outputs();
        end
      end
      make_req(mode, wb_v, dec_v, w, d);
      run_txn(wb_v, dec_v, w, d, mode == 4);
    end
    $display("test %s finished with %0d errors", name, errors - start);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("the run timed out before all tests finished");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int start;
    rst = 1'b1;
    wb_valid = 1'b0;
    dec_valid = 1'b0;
    wb_req = '0;
    dec_req = '0;
    exe_ready = 1'b0;
    lfsr = 32'hf3ef_cd15;
    errors = 0;
    checks = 0;
    reset_model();
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    run_test("reset_state", 0, N_RESET);
    run_test("register_rw", 1, N_REG);
    run_test("csr_write", 2, N_CSR);
    run_test("ecall_mret", 3, N_SYS);
    run_test("back_pressure", 4, N_BP);
    start = errors;
    compare_value("instret", m_instret, instret);
    $display("test retire_count finished with %0d errors", errors - start);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
